// File: hw/hps_input_pkg.sv
`default_nettype none

package hps_input_pkg;

	// bus and payload widths
	typedef logic [15:0] io_word_t;	// host word bus
	typedef logic [7:0]  byte_t;	// payload byte, only low half of a bus word
	typedef logic [1:0]  kms_type_t;	// kbd/mouse event type
	typedef logic [9:0]  coord_t;	// absolute mouse coordinate, unsigned

	// event types on kms_type
	localparam kms_type_t kms_mouse_x = 2'd0;
	localparam kms_type_t kms_mouse_y = 2'd1;
	localparam kms_type_t kms_key     = 2'd2;
	localparam kms_type_t kms_osd_key = 2'd3;

	// command byte, first word of every transfer
	localparam byte_t cmd_buttons = 8'd1;	// buttons in [1:0], switches in [7:4]
	localparam byte_t cmd_joy0    = 8'd2;
	localparam byte_t cmd_joy1    = 8'd3;
	localparam byte_t cmd_mouse   = 8'd4;	// dx, dy, buttons
	localparam byte_t cmd_key     = 8'd5;
	localparam byte_t cmd_osd_key = 8'd6;

	// busy countdown reload, io_wait holds this many cycles plus one
	localparam int unsigned wait_cycles = 8;

endpackage

`default_nettype wire

// File: hw/user_io.sv
`timescale 1ns/1ns
`default_nettype none

module user_io
	import hps_input_pkg::*;
(
	input  wire       clk,
	input  wire       reset,

	// host word bus
	input  wire       io_ena,
	input  wire       io_strobe,
	input  io_word_t  io_din,
	output logic      io_wait,

	// plain levels
	output byte_t     joy0,
	output byte_t     joy1,
	output logic [1:0] buttons,
	output logic [3:0] conf,
	output logic [2:0] mouse_buttons,

	// kbd/mouse events
	output logic      kms_strobe,
	output logic      kms_level,
	output kms_type_t kms_type,
	output byte_t     kms_data
);

	localparam int cnt_w = $clog2(wait_cycles + 1);

	logic [2:0]       word_cnt;	// 0 = command, saturates at 4
	byte_t            cmd;
	logic [cnt_w-1:0] busy_cnt;
	logic             word_stb;
	byte_t            payload;
	logic             ev_fire;
	kms_type_t        ev_type;

	assign word_stb = io_ena & io_strobe;
	assign payload  = io_din[7:0];

	// transfer tracking and busy flag
	always_ff @(posedge clk) begin
		if (reset) begin
			word_cnt <= '0;
			cmd      <= '0;
			busy_cnt <= '0;
			io_wait  <= 1'b0;
		end else begin
			if (busy_cnt != '0)
				busy_cnt <= busy_cnt - 1'b1;
			else
				io_wait <= 1'b0;	// countdown ran out

			if (!io_ena) begin
				// transfer closed, next word is a command again
				word_cnt <= '0;
				busy_cnt <= '0;
				io_wait  <= 1'b0;
			end else if (io_strobe) begin
				busy_cnt <= cnt_w'(wait_cycles);
				io_wait  <= 1'b1;
				if (word_cnt != 3'd4)
					word_cnt <= word_cnt + 3'd1;
				if (word_cnt == 3'd0)
					cmd <= payload;
			end
		end
	end

	// level outputs, first payload word only
	always_ff @(posedge clk) begin
		if (reset) begin
			joy0          <= '0;
			joy1          <= '0;
			buttons       <= '0;
			conf          <= '0;
			mouse_buttons <= '0;
		end else if (word_stb && word_cnt == 3'd1) begin
			case (cmd)
				cmd_buttons: begin
					buttons <= payload[1:0];
					conf    <= payload[7:4];
				end
				cmd_joy0: joy0 <= payload;
				cmd_joy1: joy1 <= payload;
				default: ;
			endcase
		end else if (word_stb && word_cnt == 3'd3 && cmd == cmd_mouse) begin
			mouse_buttons <= payload[2:0];	// third mouse word
		end
	end

	// which strobed word turns into an event
	always_comb begin
		ev_fire = 1'b0;
		ev_type = kms_key;
		if (word_stb) begin
			case (cmd)
				cmd_mouse: begin
					if (word_cnt == 3'd1) begin
						ev_fire = 1'b1;
						ev_type = kms_mouse_x;
					end else if (word_cnt == 3'd2) begin
						ev_fire = 1'b1;
						ev_type = kms_mouse_y;
					end
				end
				cmd_key: begin
					ev_fire = (word_cnt == 3'd1);
					ev_type = kms_key;
				end
				cmd_osd_key: begin
					ev_fire = (word_cnt == 3'd1);
					ev_type = kms_osd_key;
				end
				default: ;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			kms_strobe <= 1'b0;
			kms_level  <= 1'b0;
		end else begin
			kms_strobe <= ev_fire;	// single cycle per event
			if (ev_fire)
				kms_level <= ~kms_level;
		end
	end

	// event payload, only meaningful while kms_strobe is high
	always_ff @(posedge clk) begin
		if (ev_fire) begin
			kms_type <= ev_type;
			kms_data <= payload;
		end
	end

endmodule

`default_nettype wire

// File: hw/mouse_tracker.sv
`timescale 1ns/1ns
`default_nettype none

module mouse_tracker
	import hps_input_pkg::*;
#(
	parameter int unsigned pos_max_x = 639,
	parameter int unsigned pos_max_y = 479
) (
	input  wire       clk,
	input  wire       reset,

	input  wire       kms_strobe,
	input  kms_type_t kms_type,
	input  byte_t     kms_data,

	output coord_t    mouse_x,
	output coord_t    mouse_y
);

	// one sign bit plus one headroom bit above the coordinate
	localparam int sum_w = $bits(coord_t) + 2;

	localparam coord_t max_x = coord_t'(pos_max_x);
	localparam coord_t max_y = coord_t'(pos_max_y);

	logic signed [sum_w-1:0] delta;	// sign extended movement
	logic signed [sum_w-1:0] sum_x;
	logic signed [sum_w-1:0] sum_y;
	coord_t                  next_x;
	coord_t                  next_y;
	logic                    step_x;
	logic                    step_y;

	// bounds the raw sum to 0..limit
	function automatic coord_t clamp(
		input logic signed [sum_w-1:0] sum,
		input coord_t                  limit
	);
		logic signed [sum_w-1:0] lim_wide;
		lim_wide = $signed({2'b00, limit});
		if (sum < 0)
			return '0;
		else if (sum > lim_wide)
			return limit;
		else
			return sum[$bits(coord_t)-1:0];
	endfunction

	assign delta = $signed({{(sum_w - 8){kms_data[7]}}, kms_data});

	assign sum_x = $signed({2'b00, mouse_x}) + delta;
	assign sum_y = $signed({2'b00, mouse_y}) + delta;

	assign next_x = clamp(sum_x, max_x);
	assign next_y = clamp(sum_y, max_y);

	// events of type 2 and 3 belong to the key queue
	assign step_x = kms_strobe && (kms_type == kms_mouse_x);
	assign step_y = kms_strobe && (kms_type == kms_mouse_y);

	always_ff @(posedge clk) begin
		if (reset) begin
			mouse_x <= '0;
			mouse_y <= '0;
		end else begin
			if (step_x)
				mouse_x <= next_x;
			if (step_y)
				mouse_y <= next_y;
		end
	end

endmodule

`default_nettype wire

// File: hw/key_queue.sv
`timescale 1ns/1ns
`default_nettype none

module key_queue
	import hps_input_pkg::*;
#(
	parameter int unsigned key_depth = 8	// power of two, at least 2
) (
	input  wire       clk,
	input  wire       reset,

	input  wire       kms_strobe,
	input  kms_type_t kms_type,
	input  byte_t     kms_data,

	input  wire       key_read,	// drops the head entry
	output logic      key_valid,
	output logic      key_osd,
	output byte_t     key_code,
	output logic      key_overflow
);

	localparam int addr_w = $clog2(key_depth);

	logic [8:0]      mem [key_depth];	// {osd flag, code}
	logic [addr_w:0] wr_ptr;
	logic [addr_w:0] rd_ptr;
	logic            empty;
	logic            full;
	logic            wr_req;
	logic            wr_en;
	logic            rd_en;
	logic [8:0]      head;

	// extra msb tells full from empty
	assign empty = (wr_ptr == rd_ptr);
	assign full  = (wr_ptr == {~rd_ptr[addr_w], rd_ptr[addr_w-1:0]});

	assign wr_req = kms_strobe && (kms_type == kms_key || kms_type == kms_osd_key);
	assign rd_en  = key_read && !empty;	// read on empty ignored
	assign wr_en  = wr_req && (!full || rd_en);

	always_ff @(posedge clk) begin
		if (reset) begin
			wr_ptr       <= '0;
			rd_ptr       <= '0;
			key_overflow <= 1'b0;
		end else begin
			if (wr_en)
				wr_ptr <= wr_ptr + 1'b1;
			if (rd_en)
				rd_ptr <= rd_ptr + 1'b1;
			if (wr_req && full && !rd_en)
				key_overflow <= 1'b1;	// sticky until reset
		end
	end

	always_ff @(posedge clk) begin
		if (wr_en)
			mem[wr_ptr[addr_w-1:0]] <= {kms_type == kms_osd_key, kms_data};
	end

	assign head      = mem[rd_ptr[addr_w-1:0]];
	assign key_valid = !empty;
	assign key_osd   = head[8];
	assign key_code  = head[7:0];

endmodule

`default_nettype wire

// File: hw/hps_input.sv
`timescale 1ns/1ns
`default_nettype none

module hps_input
	import hps_input_pkg::*;
#(
	parameter int unsigned pos_max_x = 639,
	parameter int unsigned pos_max_y = 479,
	parameter int unsigned key_depth = 8
) (
	input  wire        clk,
	input  wire        reset,

	input  wire        io_ena,
	input  wire        io_strobe,
	input  io_word_t   io_din,
	output logic       io_wait,

	output byte_t      joy0,
	output byte_t      joy1,
	output logic [1:0] buttons,
	output logic [3:0] conf,
	output logic [2:0] mouse_buttons,
	output logic       kms_level,	// for a consumer in another clock domain

	output coord_t     mouse_x,
	output coord_t     mouse_y,

	input  wire        key_read,
	output logic       key_valid,
	output byte_t      key_code,
	output logic       key_osd,
	output logic       key_overflow
);

	// event bus shared by both consumers
	logic      kms_strobe;
	kms_type_t kms_type;
	byte_t     kms_data;

	user_io u_user_io (
		.clk           (clk),
		.reset         (reset),
		.io_ena        (io_ena),
		.io_strobe     (io_strobe),
		.io_din        (io_din),
		.io_wait       (io_wait),
		.joy0          (joy0),
		.joy1          (joy1),
		.buttons       (buttons),
		.conf          (conf),
		.mouse_buttons (mouse_buttons),
		.kms_strobe    (kms_strobe),
		.kms_level     (kms_level),
		.kms_type      (kms_type),
		.kms_data      (kms_data)
	);

	mouse_tracker #(
		.pos_max_x (pos_max_x),
		.pos_max_y (pos_max_y)
	) u_mouse_tracker (
		.clk        (clk),
		.reset      (reset),
		.kms_strobe (kms_strobe),
		.kms_type   (kms_type),
		.kms_data   (kms_data),
		.mouse_x    (mouse_x),
		.mouse_y    (mouse_y)
	);

	key_queue #(
		.key_depth (key_depth)
	) u_key_queue (
		.clk          (clk),
		.reset        (reset),
		.kms_strobe   (kms_strobe),
		.kms_type     (kms_type),
		.kms_data     (kms_data),
		.key_read     (key_read),
		.key_valid    (key_valid),
		.key_osd      (key_osd),
		.key_code     (key_code),
		.key_overflow (key_overflow)
	);

endmodule

`default_nettype wire

// File: sim/hps_input_checker.sv
`timescale 1ns/1ns
`default_nettype none

module hps_input_checker
	import hps_input_pkg::*;
#(
	parameter int unsigned pos_max_x = 639,
	parameter int unsigned pos_max_y = 479,
	parameter int unsigned key_depth = 8
) (
	input  wire        clk,
	input  wire        reset,
	input  wire        io_ena,
	input  wire        io_strobe,
	input  wire [15:0] io_din,
	input  wire        key_read,
	input  wire        io_wait,
	input  wire [7:0]  joy0,
	input  wire [7:0]  joy1,
	input  wire [1:0]  buttons,
	input  wire [3:0]  conf,
	input  wire [2:0]  mouse_buttons,
	input  wire        kms_level,
	input  wire [9:0]  mouse_x,
	input  wire [9:0]  mouse_y,
	input  wire        key_valid,
	input  wire [7:0]  key_code,
	input  wire        key_osd,
	input  wire        key_overflow,
	output int         errors
);

	// expected state after the most recent rising edge
	int          words;	// payload index within the transfer
	logic [7:0]  cmd_m;
	int          remain;	// edges left until io_wait drops
	logic [7:0]  e_joy0;
	logic [7:0]  e_joy1;
	logic [1:0]  e_buttons;
	logic [3:0]  e_conf;
	logic [2:0]  e_mbtn;
	logic        e_level;
	logic        ev_pend;	// event seen by the consumers next edge
	logic [1:0]  ev_kind;
	logic [7:0]  ev_data;
	int          e_x;
	int          e_y;
	logic [8:0]  fifo[$];	// {osd, code}
	logic        e_ovf;
	bit          seen_edge = 1'b0;

	task automatic clear_model();
		words = 0;
		cmd_m = '0;
		remain = 0;
		e_joy0 = '0;
		e_joy1 = '0;
		e_buttons = '0;
		e_conf = '0;
		e_mbtn = '0;
		e_level = 1'b0;
		ev_pend = 1'b0;
		ev_kind = '0;
		ev_data = '0;
		e_x = 0;
		e_y = 0;
		fifo.delete();
		e_ovf = 1'b0;
	endtask

	task automatic check(input string name, input logic [31:0] exp, input logic [31:0] act);
		if (act !== exp) begin
			errors++;
			$display("MISMATCH t=%0t %s expected %0h actual %0h", $time, name, exp, act);
		end
	endtask

	// signed move, then held inside 0..limit
	function automatic int moved(input int pos, input logic [7:0] d, input int limit);
		int sum;
		sum = pos + int'(d);
		if (d[7])
			sum = sum - 256;
		if (sum < 0)
			return 0;
		if (sum > limit)
			return limit;
		return sum;
	endfunction

	task automatic compare_outputs();
		check("io_wait", remain != 0, io_wait);
		check("joy0", e_joy0, joy0);
		check("joy1", e_joy1, joy1);
		check("buttons", e_buttons, buttons);
		check("conf", e_conf, conf);
		check("mouse_buttons", e_mbtn, mouse_buttons);
		check("kms_level", e_level, kms_level);
		check("mouse_x", e_x, mouse_x);
		check("mouse_y", e_y, mouse_y);
		check("key_valid", fifo.size() != 0, key_valid);
		check("key_overflow", e_ovf, key_overflow);
		if (fifo.size() != 0) begin	// head is don't care when empty
			check("key_code", fifo[0][7:0], key_code);
			check("key_osd", fifo[0][8], key_osd);
		end
	endtask

	// predicts the effect of the coming rising edge
	task automatic advance();
		logic [7:0] b;
		logic       rd;
		logic       wr;
		b = io_din[7:0];
		if (reset) begin
			clear_model();
		end else begin
			// consumers act on the event raised one edge earlier
			if (ev_pend && ev_kind == kms_mouse_x)
				e_x = moved(e_x, ev_data, pos_max_x);
			if (ev_pend && ev_kind == kms_mouse_y)
				e_y = moved(e_y, ev_data, pos_max_y);
			rd = key_read && fifo.size() != 0;
			wr = ev_pend && (ev_kind == kms_key || ev_kind == kms_osd_key);
			if (rd)
				void'(fifo.pop_front());
			if (wr) begin
				if (fifo.size() < key_depth)
					fifo.push_back({ev_kind == kms_osd_key, ev_data});
				else
					e_ovf = 1'b1;	// dropped
			end
			ev_pend = 1'b0;

			if (!io_ena) begin
				words = 0;
				remain = 0;
			end else begin
				if (remain > 0)
					remain--;
				if (io_strobe) begin
					remain = wait_cycles + 1;
					if (words == 0) begin
						cmd_m = b;
					end else if (words == 1) begin
						case (cmd_m)
							cmd_buttons: begin
								e_buttons = b[1:0];
								e_conf = b[7:4];
							end
							cmd_joy0: e_joy0 = b;
							cmd_joy1: e_joy1 = b;
							cmd_mouse: {ev_pend, ev_kind} = {1'b1, kms_mouse_x};
							cmd_key: {ev_pend, ev_kind} = {1'b1, kms_key};
							cmd_osd_key: {ev_pend, ev_kind} = {1'b1, kms_osd_key};
							default: ;
						endcase
					end else if (words == 2 && cmd_m == cmd_mouse) begin
						{ev_pend, ev_kind} = {1'b1, kms_mouse_y};
					end else if (words == 3 && cmd_m == cmd_mouse) begin
						e_mbtn = b[2:0];
					end
					ev_data = b;
					words++;
				end
			end
			if (ev_pend)
				e_level = ~e_level;
		end
	endtask

	initial begin
		errors = 0;
		clear_model();
	end

	always @(posedge clk)
		seen_edge <= 1'b1;

	// outputs settle well before the falling edge
	always @(negedge clk) begin
		if (seen_edge) begin
			compare_outputs();
			advance();
		end
	end

endmodule

`default_nettype wire

// File: sim/hps_input_tb.sv
`timescale 1ns/1ns
`default_nettype none

module hps_input_tb
	import hps_input_pkg::*;
();

	localparam int clk_period = 100;
	localparam int max_x      = 639;
	localparam int max_y      = 479;
	localparam int depth      = 4;	// small so overflow comes quickly

	logic        clk;
	logic        reset;
	logic        io_ena;
	logic        io_strobe;
	logic [15:0] io_din;
	logic        key_read;
	logic        io_wait;
	logic [7:0]  joy0;
	logic [7:0]  joy1;
	logic [1:0]  buttons;
	logic [3:0]  conf;
	logic [2:0]  mouse_buttons;
	logic        kms_level;
	logic [9:0]  mouse_x;
	logic [9:0]  mouse_y;
	logic        key_valid;
	logic [7:0]  key_code;
	logic        key_osd;
	logic        key_overflow;
	int          err_count;

	logic [19:0] rows[$];	// {reset, io_ena, io_strobe, io_din, key_read}
	bit          table_ready = 1'b0;
	logic [31:0] lfsr_state = 32'he74b;

	hps_input #(.pos_max_x(max_x), .pos_max_y(max_y), .key_depth(depth)) dut0 (
		.clk(clk), .reset(reset), .io_ena(io_ena), .io_strobe(io_strobe),
		.io_din(io_din), .io_wait(io_wait), .joy0(joy0), .joy1(joy1),
		.buttons(buttons), .conf(conf), .mouse_buttons(mouse_buttons),
		.kms_level(kms_level), .mouse_x(mouse_x), .mouse_y(mouse_y),
		.key_read(key_read), .key_valid(key_valid), .key_code(key_code),
		.key_osd(key_osd), .key_overflow(key_overflow)
	);

	hps_input_checker #(.pos_max_x(max_x), .pos_max_y(max_y), .key_depth(depth)) chk0 (
		.clk(clk), .reset(reset), .io_ena(io_ena), .io_strobe(io_strobe),
		.io_din(io_din), .key_read(key_read), .io_wait(io_wait), .joy0(joy0),
		.joy1(joy1), .buttons(buttons), .conf(conf), .mouse_buttons(mouse_buttons),
		.kms_level(kms_level), .mouse_x(mouse_x), .mouse_y(mouse_y),
		.key_valid(key_valid), .key_code(key_code), .key_osd(key_osd),
		.key_overflow(key_overflow), .errors(err_count)
	);

	// galois form, taps 32,22,2,1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		if (s[0])
			return (s >> 1) ^ 32'h8020_0003;
		return s >> 1;
	endfunction

	function automatic logic [7:0] random_byte();
		logic [7:0] b;
		for (int i = 0; i < 8; i++) begin
			b[i] = lfsr_state[0];	// one step per bit
			lfsr_state = lfsr_next(lfsr_state);
		end
		return b;
	endfunction

	task automatic put_row(input logic rst, input logic ena, input logic stb,
			input logic [15:0] din, input logic rd);
		rows.push_back({rst, ena, stb, din, rd});
	endtask

	task automatic idle_rows(input int n);
		repeat (n) put_row(1'b0, 1'b0, 1'b0, 16'h0000, 1'b0);
	endtask

	task automatic send_word(input logic [15:0] d);
		put_row(1'b0, 1'b1, 1'b0, 16'h0000, 1'b0);	// gap between words
		put_row(1'b0, 1'b1, 1'b1, d, 1'b0);
	endtask

	task automatic close_transfer();
		put_row(1'b0, 1'b1, 1'b0, 16'h0000, 1'b0);
		idle_rows(2);
	endtask

	task automatic mouse_transfer(input logic [7:0] dx, input logic [7:0] dy,
			input logic [7:0] mb);
		send_word({8'h00, cmd_mouse});
		send_word({8'h3c, dx});	// high byte is junk
		send_word({8'h00, dy});
		send_word({8'h00, mb});
		close_transfer();
	endtask

	task automatic key_transfer(input logic [7:0] cmd, input logic [7:0] code);
		send_word({8'h00, cmd});
		send_word({8'h00, code});
		close_transfer();
	endtask

	task automatic read_key();
		put_row(1'b0, 1'b0, 1'b0, 16'h0000, 1'b1);
		idle_rows(1);
	endtask

	task automatic build_table();
		logic [7:0] dx;
		logic [7:0] dy;
		logic [7:0] mb;
		// levels, extra words, countdown with io_ena still high
		send_word({8'h00, cmd_buttons});
		send_word(16'ha5f3);
		send_word(16'h0011);
		send_word(16'h00ff);
		repeat (12) put_row(1'b0, 1'b1, 1'b0, 16'h0000, 1'b0);
		close_transfer();
		key_transfer(cmd_joy0, 8'h5a);
		key_transfer(cmd_joy1, random_byte());
		key_transfer(8'h09, 8'hee);	// unknown command
		// mouse moves, then clamping at both ends
		send_word({8'h00, cmd_mouse});
		send_word(16'h0064);
		send_word(16'h0032);
		send_word(16'h0005);
		send_word(16'h0006);	// fourth word, buttons stay at 5
		close_transfer();
		mouse_transfer(8'h80, 8'h80, 8'h02);
		repeat (6) mouse_transfer(8'h7f, 8'h7f, 8'h01);
		repeat (4) begin
			dx = random_byte();
			dy = random_byte();
			mb = random_byte();
			mouse_transfer(dx, dy, mb);
		end
		// key order, one read too many
		key_transfer(cmd_key, 8'h1c);
		key_transfer(cmd_osd_key, 8'h2a);
		key_transfer(cmd_key, random_byte());
		repeat (4) read_key();
		// overflow, then read and write together on a full queue
		for (int i = 0; i < 6; i++)
			key_transfer(i[0] ? cmd_osd_key : cmd_key, 8'h40 + 8'(i));
		send_word({8'h00, cmd_key});
		send_word(16'h0077);
		put_row(1'b0, 1'b1, 1'b0, 16'h0000, 1'b1);
		close_transfer();
		repeat (5) read_key();
		// aborted transfer, then reset in the middle of another
		send_word({8'h00, cmd_mouse});
		send_word(16'h0010);
		idle_rows(2);
		key_transfer(cmd_joy1, 8'h42);
		send_word({8'h00, cmd_joy0});
		put_row(1'b1, 1'b1, 1'b0, 16'h0000, 1'b0);
		put_row(1'b1, 1'b1, 1'b0, 16'h0000, 1'b0);
		send_word({8'h00, cmd_joy1});	// must be taken as a command
		send_word(16'h0024);
		close_transfer();
		idle_rows(4);
	endtask

	initial begin
		clk = 1'b0;
		forever #(clk_period / 2) clk = ~clk;
	end

	initial begin
		reset     = 1'b1;
		io_ena    = 1'b0;
		io_strobe = 1'b0;
		io_din    = 16'h0000;
		key_read  = 1'b0;
		build_table();
		table_ready = 1'b1;
		repeat (2) @(posedge clk);
		foreach (rows[i]) begin
			{reset, io_ena, io_strobe, io_din, key_read} <= rows[i];
			@(posedge clk);
		end
		{reset, io_ena, io_strobe, io_din, key_read} <= '0;
		while (io_wait)
			@(negedge clk);
		repeat (3) @(posedge clk);
		$display("errors: %0d", err_count);
		if (err_count == 0)
			$display("*** PASSED ***");
		else
			$display("*** FAILED ***");
		$finish;
	end

	// watchdog
	initial begin
		wait (table_ready);
		#((rows.size() + 20) * clk_period);
		$display("timeout: the run did not finish in time");
		$display("errors: %0d", err_count);
		$display("*** FAILED ***");
		$finish;
	end

endmodule

`default_nettype wire

// File: hps_input.f
hw/hps_input_pkg.sv
hw/user_io.sv
hw/mouse_tracker.sv
hw/key_queue.sv
hw/hps_input.sv
sim/hps_input_checker.sv
sim/hps_input_tb.sv
